//--- logic/rs5_isa_pkg.sv
// rs5_lite instruction set definitions
// widths, opcodes, funct fields and the decoded operation
package rs5_isa_pkg;

    // data path and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////////////////////////
    // major opcodes
    ////////////////////////////////////////
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    ////////////////////////////////////////
    // funct3 and funct7 fields
    ////////////////////////////////////////
    // load and store sizes
    localparam logic [2:0] F3_B   = 3'b000;
    localparam logic [2:0] F3_H   = 3'b001;
    localparam logic [2:0] F3_W   = 3'b010;
    localparam logic [2:0] F3_BU  = 3'b100;
    localparam logic [2:0] F3_HU  = 3'b101;

    // alu, shared by register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // sub differs from add only here
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // decoded operation, nop must stay at zero since bubbles are all zeros
    typedef enum logic [4:0] {
        NOP, ADD, SUB, AND, OR, XOR, LUI,
        LB, LBU, LH, LHU, LW, SW,
        BEQ, BNE, JAL
    } instr_op_e;

endpackage

//--- logic/rs5_pipe_pkg.sv
// rs5_lite pipeline records
// stage links, forwarding paths and the data memory request
package rs5_pipe_pkg;

    // decode to execute register
    typedef struct packed {
        rs5_isa_pkg::word_t     pc;
        rs5_isa_pkg::instr_op_e op;
        rs5_isa_pkg::reg_addr_t rd;
        logic                   rd_we;
        rs5_isa_pkg::word_t     rs1_data;
        rs5_isa_pkg::word_t     rs2_data;
        // immediate, or rs2 for register ops
        rs5_isa_pkg::word_t     second_operand;
        // pc plus branch or jal offset
        rs5_isa_pkg::word_t     imm_target;
    } dec_exec_t;

    // execute to retire register
    typedef struct packed {
        rs5_isa_pkg::instr_op_e op;
        rs5_isa_pkg::reg_addr_t rd;
        logic                   rd_we;
        rs5_isa_pkg::word_t     result;
    } exec_ret_t;

    // one register write, for both forwarding paths
    typedef struct packed {
        logic                   we;
        rs5_isa_pkg::reg_addr_t rd;
        rs5_isa_pkg::word_t     value;
    } fwd_t;

    typedef struct packed {
        logic               jump;
        rs5_isa_pkg::word_t target;
    } redirect_t;

    typedef struct packed {
        logic               read_en;
        logic [3:0]         write_strobe;
        rs5_isa_pkg::word_t address;
        rs5_isa_pkg::word_t wdata;
    } mem_req_t;

endpackage

//--- logic/fetch.sv
`timescale 1ns/1ps
// instruction fetch
// program counter, redirect and the hand-off of returning words to decode
module fetch #(
    parameter rs5_isa_pkg::word_t START_ADDRESS = '0
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable_i,
    input  rs5_pipe_pkg::redirect_t redirect_i,
    input  rs5_isa_pkg::word_t      instruction_data_i,
    output rs5_isa_pkg::word_t      instruction_address_o,
    output rs5_isa_pkg::word_t      instruction_o,
    output rs5_isa_pkg::word_t      pc_o,
    output logic                    jumping_o
);
    import rs5_isa_pkg::*;

    // address requested now
    word_t pc;
    // address of the word returning now
    word_t pc_q;
    logic  jumping_q;

    // frozen: ask again for the word decode is holding
    assign instruction_address_o = enable_i ? pc : pc_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc        <= START_ADDRESS;
            pc_q      <= START_ADDRESS;
            // nothing was requested before reset, so drop the first word
            jumping_q <= 1'b1;
        end else if (enable_i) begin
            pc_q      <= pc;
            // word in flight was fetched on the old path
            jumping_q <= redirect_i.jump;
            if (redirect_i.jump)
                pc <= redirect_i.target;
            else
                pc <= pc + word_t'(4);
        end
    end

    assign instruction_o = instruction_data_i;
    assign pc_o          = pc_q;
    assign jumping_o     = jumping_q;

endmodule

//--- logic/decode.sv
`timescale 1ns/1ps
// instruction decode
// operand forwarding, load-use detection and the decode to execute register
module decode (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable_i,
    input  rs5_isa_pkg::word_t      instruction_i,
    input  rs5_isa_pkg::word_t      pc_i,
    input  logic                    jumping_i,
    input  rs5_pipe_pkg::redirect_t redirect_i,
    output rs5_isa_pkg::reg_addr_t  rs1_o,
    output rs5_isa_pkg::reg_addr_t  rs2_o,
    input  rs5_isa_pkg::word_t      rs1_data_i,
    input  rs5_isa_pkg::word_t      rs2_data_i,
    input  rs5_pipe_pkg::fwd_t      exec_fwd_i,
    input  rs5_pipe_pkg::fwd_t      wb_fwd_i,
    input  logic                    exec_load_i,
    output rs5_pipe_pkg::dec_exec_t dec_o,
    output logic                    hazard_o
);
    import rs5_isa_pkg::*;
    import rs5_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
    instr_op_e  alu_op;
    instr_op_e  op;
    logic       killed;
    dec_exec_t  dec_d;

    // newest value first, execute then writeback then the bank
    function automatic word_t forward(reg_addr_t rs, word_t bank_value);
        if (exec_fwd_i.we && exec_fwd_i.rd == rs)
            return exec_fwd_i.value;
        if (wb_fwd_i.we && wb_fwd_i.rd == rs)
            return wb_fwd_i.value;
        return bank_value;
    endfunction

    assign opcode = instruction_i[6:0];
    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];
    assign funct7 = instruction_i[31:25];

    ////////////////////////////////////////
    // immediates
    ////////////////////////////////////////
    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};

    ////////////////////////////////////////
    // operation
    ////////////////////////////////////////
    always_comb begin
        case (funct3)
            F3_ADD:  alu_op = ADD;
            F3_XOR:  alu_op = XOR;
            F3_OR:   alu_op = OR;
            F3_AND:  alu_op = AND;
            default: alu_op = NOP;
        endcase
    end

    // anything not listed falls through as nop
    always_comb begin
        op = NOP;
        case (opcode)
            OPC_LUI:    op = LUI;
            OPC_JAL:    op = JAL;
            OPC_OP_IMM: op = alu_op;
            OPC_OP: begin
                if (funct7 == '0)
                    op = alu_op;
                else if (funct7 == F7_SUB && funct3 == F3_ADD)
                    op = SUB;
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_B:    op = LB;
                    F3_BU:   op = LBU;
                    F3_H:    op = LH;
                    F3_HU:   op = LHU;
                    F3_W:    op = LW;
                    default: op = NOP;
                endcase
            end
            OPC_STORE:  op = (funct3 == F3_W) ? SW : NOP;
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ)
                    op = BEQ;
                else if (funct3 == F3_BNE)
                    op = BNE;
            end
            default:    op = NOP;
        endcase
    end

    ////////////////////////////////////////
    // operands and hazard
    ////////////////////////////////////////
    always_comb begin
        dec_d.pc       = pc_i;
        dec_d.op       = op;
        dec_d.rd       = rd;
        // x0 never gets a write enable, so it is never forwarded either
        dec_d.rd_we    = (rd != '0) && !(op inside {NOP, SW, BEQ, BNE});
        dec_d.rs1_data = forward(rs1_o, rs1_data_i);
        dec_d.rs2_data = forward(rs2_o, rs2_data_i);
        case (opcode)
            OPC_OP:    dec_d.second_operand = dec_d.rs2_data;
            OPC_STORE: dec_d.second_operand = imm_s;
            OPC_LUI:   dec_d.second_operand = imm_u;
            default:   dec_d.second_operand = imm_i;
        endcase
        dec_d.imm_target = pc_i + ((op == JAL) ? imm_j : imm_b);
    end

    // wrong path: taken jump in execute now, or word fetched before it
    assign killed = jumping_i || redirect_i.jump;

    // load result not ready until writeback
    assign hazard_o = !killed && exec_load_i && exec_fwd_i.we
                      && (exec_fwd_i.rd == rs1_o || exec_fwd_i.rd == rs2_o);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dec_o <= '0;
        end else if (enable_i) begin
            // bubble into execute
            if (killed || hazard_o)
                dec_o <= '0;
            else
                dec_o <= dec_d;
        end
    end

endmodule

//--- logic/regbank.sv
`timescale 1ns/1ps
// register bank, x1 to x31 in flip-flops
// two combinational read ports, one write port from writeback
module regbank (
    input  logic                   clk,
    input  logic                   reset_n,
    input  rs5_isa_pkg::reg_addr_t rs1_i,
    input  rs5_isa_pkg::reg_addr_t rs2_i,
    input  rs5_pipe_pkg::fwd_t     wb_i,
    output rs5_isa_pkg::word_t     data1_o,
    output rs5_isa_pkg::word_t     data2_o
);
    import rs5_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i <= 31; i++)
                regs[i] <= '0;
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // x0 reads as zero
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps
// execute stage
// alu, branch resolution, data memory request and the execute to retire register
module execute (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    stall_i,
    input  rs5_pipe_pkg::dec_exec_t dec_i,
    output rs5_pipe_pkg::exec_ret_t ret_o,
    output rs5_pipe_pkg::fwd_t      fwd_o,
    output rs5_pipe_pkg::redirect_t redirect_o,
    output rs5_pipe_pkg::mem_req_t  mem_o,
    output logic                    load_o
);
    import rs5_isa_pkg::*;

    word_t alu_result;
    word_t sum;
    logic  equal;

    // one adder for add, addi and load/store addresses
    assign sum    = dec_i.rs1_data + dec_i.second_operand;
    assign equal  = dec_i.rs1_data == dec_i.rs2_data;
    assign load_o = dec_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb begin
        case (dec_i.op)
            ADD:     alu_result = sum;
            SUB:     alu_result = dec_i.rs1_data - dec_i.second_operand;
            AND:     alu_result = dec_i.rs1_data & dec_i.second_operand;
            OR:      alu_result = dec_i.rs1_data | dec_i.second_operand;
            XOR:     alu_result = dec_i.rs1_data ^ dec_i.second_operand;
            LUI:     alu_result = dec_i.second_operand;
            // link value
            JAL:     alu_result = dec_i.pc + word_t'(4);
            default: alu_result = '0;
        endcase
    end

    // same cycle as the instruction sits here
    assign redirect_o.jump   = (dec_i.op == JAL)
                               || (dec_i.op == BEQ && equal)
                               || (dec_i.op == BNE && !equal);
    assign redirect_o.target = dec_i.imm_target;

    ////////////////////////////////////////
    // memory request
    ////////////////////////////////////////
    assign mem_o.read_en      = load_o;
    // sw only, so all four lanes
    assign mem_o.write_strobe = (dec_i.op == SW) ? 4'b1111 : 4'b0000;
    assign mem_o.address      = sum;
    assign mem_o.wdata        = dec_i.rs2_data;

    // loads forward garbage here, decode holds them back with a hazard
    assign fwd_o.we    = dec_i.rd_we;
    assign fwd_o.rd    = dec_i.rd;
    assign fwd_o.value = alu_result;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ret_o <= '0;
        end else if (!stall_i) begin
            ret_o.op     <= dec_i.op;
            ret_o.rd     <= dec_i.rd;
            ret_o.rd_we  <= dec_i.rd_we;
            // loads carry the address, retire wants its low bits
            ret_o.result <= load_o ? sum : alu_result;
        end
    end

endmodule

//--- logic/retire.sv
`timescale 1ns/1ps
// retire stage
// load lane selection and extension, writeback value to the bank and decode
module retire (
    input  rs5_pipe_pkg::exec_ret_t ret_i,
    input  rs5_isa_pkg::word_t      mem_data_i,
    input  logic [1:0]              address_lsb_i,
    output rs5_pipe_pkg::fwd_t      wb_o
);
    import rs5_isa_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // lanes picked by the low address bits
    assign load_byte = mem_data_i[{address_lsb_i, 3'b000} +: 8];
    assign load_half = address_lsb_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

    always_comb begin
        wb_o.we = ret_i.rd_we;
        wb_o.rd = ret_i.rd;
        case (ret_i.op)
            LB:      wb_o.value = {{24{load_byte[7]}}, load_byte};
            LBU:     wb_o.value = {24'b0, load_byte};
            LH:      wb_o.value = {{16{load_half[15]}}, load_half};
            LHU:     wb_o.value = {16'b0, load_half};
            LW:      wb_o.value = mem_data_i;
            // alu and link results pass straight through
            default: wb_o.value = ret_i.result;
        endcase
    end

endmodule

//--- logic/rs5_lite.sv
`timescale 1ns/1ps
// rs5_lite core top
// four-stage rv32i subset pipeline with instruction and data memory ports
module rs5_lite #(
    parameter rs5_isa_pkg::word_t START_ADDRESS = '0
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stall_i,
    input  rs5_isa_pkg::word_t instruction_i,
    input  rs5_isa_pkg::word_t mem_data_i,
    output rs5_isa_pkg::word_t instruction_address_o,
    output rs5_isa_pkg::word_t mem_address_o,
    output rs5_isa_pkg::word_t mem_data_o,
    output logic               mem_operation_enable_o,
    output logic [3:0]         mem_write_enable_o
);
    import rs5_isa_pkg::*;
    import rs5_pipe_pkg::*;

    ////////////////////////////////////////
    // pipeline signals
    ////////////////////////////////////////
    logic      enable_fetch;
    logic      enable_decode;
    logic      hazard;
    logic      jumping;
    logic      exec_load;
    word_t     instruction_decode;
    word_t     pc_decode;
    reg_addr_t rs1, rs2;
    word_t     bank_data1, bank_data2;
    dec_exec_t dec_exec;
    exec_ret_t exec_ret;
    fwd_t      exec_fwd;
    fwd_t      wb_fwd;
    redirect_t redirect;
    mem_req_t  mem_req;
    logic      stall_q;
    word_t     load_data_q;
    word_t     load_data;

    // hazard holds fetch only, decode sends a bubble
    assign enable_fetch  = !(stall_i || hazard);
    assign enable_decode = !stall_i;

    fetch #(
        .START_ADDRESS(START_ADDRESS)
    ) fetch1 (
        .clk                  (clk),
        .reset_n              (reset_n),
        .enable_i             (enable_fetch),
        .redirect_i           (redirect),
        .instruction_data_i   (instruction_i),
        .instruction_address_o(instruction_address_o),
        .instruction_o        (instruction_decode),
        .pc_o                 (pc_decode),
        .jumping_o            (jumping)
    );

    decode decode1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_decode),
        .instruction_i(instruction_decode),
        .pc_i         (pc_decode),
        .jumping_i    (jumping),
        .redirect_i   (redirect),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_data_i   (bank_data1),
        .rs2_data_i   (bank_data2),
        .exec_fwd_i   (exec_fwd),
        .wb_fwd_i     (wb_fwd),
        .exec_load_i  (exec_load),
        .dec_o        (dec_exec),
        .hazard_o     (hazard)
    );

    regbank regbank1 (
        .clk    (clk),
        .reset_n(reset_n),
        .rs1_i  (rs1),
        .rs2_i  (rs2),
        .wb_i   (wb_fwd),
        .data1_o(bank_data1),
        .data2_o(bank_data2)
    );

    execute execute1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall_i   (stall_i),
        .dec_i     (dec_exec),
        .ret_o     (exec_ret),
        .fwd_o     (exec_fwd),
        .redirect_o(redirect),
        .mem_o     (mem_req),
        .load_o    (exec_load)
    );

    retire retire1 (
        .ret_i        (exec_ret),
        .mem_data_i   (load_data),
        .address_lsb_i(exec_ret.result[1:0]),
        .wb_o         (wb_fwd)
    );

    ////////////////////////////////////////
    // memory port
    ////////////////////////////////////////
    // read data is valid only the cycle after the request,
    // so hold it while a stall keeps the load in retire
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            stall_q <= 1'b0;
        else
            stall_q <= stall_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_q)
            load_data_q <= mem_data_i;
    end

    assign load_data = stall_q ? load_data_q : mem_data_i;

    assign mem_operation_enable_o = mem_req.read_en || (mem_req.write_strobe != 4'b0000);
    assign mem_write_enable_o     = mem_req.write_strobe;
    assign mem_address_o          = mem_req.address;
    assign mem_data_o             = mem_req.wdata;

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
// testbench clock source
// free running, 50 percent duty cycle
module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // half period per phase
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- verif/rs5_lite_tb.sv
`timescale 1ns/1ps
// rs5_lite testbench
// program table with expected stores, memory models, random stall and report
module rs5_lite_tb;
    import rs5_isa_pkg::*;

    localparam word_t START_ADDRESS = 32'h0000_0000;
    localparam int    NUM_TESTS     = 6;
    localparam int    MAX_WORDS     = 64;
    localparam int    MAX_STORES    = 8;
    localparam int    STORE_TIMEOUT = 200;
    localparam int    QUIET_CYCLES  = 30;

    logic       clk;
    logic       reset_n;
    logic       stall_i       = 1'b0;
    word_t      instruction_i = '0;
    word_t      mem_data_i    = '0;
    word_t      instruction_address_o;
    word_t      mem_address_o;
    word_t      mem_data_o;
    logic       mem_operation_enable_o;
    logic [3:0] mem_write_enable_o;

    // memories with one word per entry
    word_t imem [MAX_WORDS];
    word_t dmem [MAX_WORDS];
    word_t imem_offset;

    ////////////////////////////////////////
    // test table
    ////////////////////////////////////////
    string test_name  [NUM_TESTS];
    bit    stall_mode [NUM_TESTS];
    word_t prog_tab   [NUM_TESTS][MAX_WORDS];
    int    prog_len   [NUM_TESTS];
    word_t exp_addr   [NUM_TESTS][MAX_STORES];
    word_t exp_data   [NUM_TESTS][MAX_STORES];
    int    exp_count  [NUM_TESTS];

    // observed stores of the running test
    word_t store_addr_q [$];
    word_t store_data_q [$];
    word_t store_strb_q [$];
    int    reads_before_store;

    string cur_name;
    int    errors;
    int    test_errors;
    int    passed;
    bit    random_stall = 1'b0;
    word_t lcg_state    = 32'd46;

    tb_clock_gen #(
        .PERIOD_NS(20)
    ) clock_gen (
        .clk_o(clk)
    );

    rs5_lite #(
        .START_ADDRESS(START_ADDRESS)
    ) dut (
        .clk                   (clk),
        .reset_n               (reset_n),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .mem_data_i            (mem_data_i),
        .instruction_address_o (instruction_address_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o    (mem_write_enable_o)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic word_t lcg_next(word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // rv32i instruction formats
    function automatic word_t i_type(logic [6:0] opcode, logic [2:0] f3, int rd, int rs1,
                                     int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opcode};
    endfunction

    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    // word stores only
    function automatic word_t s_type(int rs2, int rs1, int imm);
        logic [11:0] offset;
        offset = 12'(imm);
        return {offset[11:5], 5'(rs2), 5'(rs1), F3_W, offset[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
        logic [12:0] offset;
        offset = 13'(imm);
        return {offset[12], offset[10:5], 5'(rs2), 5'(rs1), f3, offset[4:1], offset[11],
                OPC_BRANCH};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        logic [20:0] offset;
        offset = 21'(imm);
        return {offset[20], offset[10:1], offset[11], offset[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic word_t u_type(int rd, int imm20);
        return {20'(imm20), 5'(rd), OPC_LUI};
    endfunction

    task automatic emit(int t, word_t word);
        prog_tab[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic expect_store(int t, word_t addr, word_t data);
        exp_addr[t][exp_count[t]] = addr;
        exp_data[t][exp_count[t]] = data;
        exp_count[t]++;
    endtask

    task automatic check_value(string what, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t]  = 0;
            exp_count[t] = 0;
        end
        // chained alu ops each working on the previous result
        test_name[0] = "alu_chain";
        emit(0, u_type(1, 'h12345));
        emit(0, i_type(OPC_OP_IMM, F3_ADD, 1, 1, 'h678));
        emit(0, r_type(7'b0000000, F3_ADD, 2, 1, 1));
        emit(0, r_type(F7_SUB, F3_ADD, 3, 2, 1));
        emit(0, r_type(7'b0000000, F3_XOR, 4, 3, 2));
        emit(0, r_type(7'b0000000, F3_AND, 5, 4, 1));
        emit(0, r_type(7'b0000000, F3_OR, 6, 5, 2));
        emit(0, s_type(6, 0, 16));
        // write to x0 must be lost
        emit(0, i_type(OPC_OP_IMM, F3_ADD, 0, 6, 5));
        emit(0, s_type(0, 0, 20));
        emit(0, s_type(2, 0, 0));
        emit(0, s_type(3, 0, 4));
        emit(0, s_type(4, 0, 8));
        emit(0, s_type(5, 0, 12));
        emit(0, j_type(0, 0));
        expect_store(0, 32'd16, 32'h367C_FEF8);
        expect_store(0, 32'd20, 32'h0000_0000);
        expect_store(0, 32'd0,  32'h2468_ACF0);
        expect_store(0, 32'd4,  32'h1234_5678);
        expect_store(0, 32'd8,  32'h365C_FA88);
        expect_store(0, 32'd12, 32'h1214_5208);
        // store, load-use, then every sub-word load
        test_name[1] = "load_store";
        emit(1, u_type(1, 'h89ABD));
        // 0xdef is -0x211 sign extended
        emit(1, i_type(OPC_OP_IMM, F3_ADD, 1, 1, 'hDEF));
        emit(1, s_type(1, 0, 32));
        emit(1, i_type(OPC_LOAD, F3_W, 2, 0, 32));
        emit(1, r_type(7'b0000000, F3_ADD, 3, 2, 1));
        emit(1, s_type(3, 0, 36));
        emit(1, i_type(OPC_LOAD, F3_B, 4, 0, 33));
        emit(1, s_type(4, 0, 40));
        emit(1, i_type(OPC_LOAD, F3_BU, 5, 0, 35));
        emit(1, s_type(5, 0, 44));
        emit(1, i_type(OPC_LOAD, F3_H, 6, 0, 34));
        emit(1, s_type(6, 0, 48));
        emit(1, i_type(OPC_LOAD, F3_HU, 7, 0, 32));
        emit(1, s_type(7, 0, 52));
        emit(1, i_type(OPC_LOAD, F3_B, 8, 0, 32));
        emit(1, s_type(8, 0, 56));
        emit(1, j_type(0, 0));
        expect_store(1, 32'd32, 32'h89AB_CDEF);
        expect_store(1, 32'd36, 32'h1357_9BDE);
        expect_store(1, 32'd40, 32'hFFFF_FFCD);
        expect_store(1, 32'd44, 32'h0000_0089);
        expect_store(1, 32'd48, 32'hFFFF_89AB);
        expect_store(1, 32'd52, 32'h0000_CDEF);
        expect_store(1, 32'd56, 32'hFFFF_FFEF);
        // taken beq, not-taken bne, jal with link
        test_name[2] = "branch_jump";
        emit(2, i_type(OPC_OP_IMM, F3_ADD, 1, 0, 7));
        emit(2, i_type(OPC_OP_IMM, F3_ADD, 2, 0, 7));
        emit(2, b_type(F3_BEQ, 1, 2, 12));
        emit(2, s_type(1, 0, 0));
        emit(2, s_type(2, 0, 4));
        emit(2, b_type(F3_BNE, 1, 2, 12));
        emit(2, s_type(1, 0, 8));
        emit(2, j_type(3, 12));
        emit(2, s_type(1, 0, 12));
        emit(2, s_type(2, 0, 16));
        emit(2, s_type(3, 0, 20));
        emit(2, i_type(OPC_OP_IMM, F3_ADD, 4, 3, 1));
        emit(2, s_type(4, 0, 24));
        emit(2, j_type(0, 0));
        expect_store(2, 32'd8,  32'd7);
        // jal sits at offset 28
        expect_store(2, 32'd20, START_ADDRESS + 32'd32);
        expect_store(2, 32'd24, START_ADDRESS + 32'd33);
        // same programs again under random stall
        for (int t = 0; t < 3; t++) begin
            test_name[t + 3]  = {test_name[t], "_stall"};
            stall_mode[t]     = 1'b0;
            stall_mode[t + 3] = 1'b1;
            prog_len[t + 3]   = prog_len[t];
            exp_count[t + 3]  = exp_count[t];
            prog_tab[t + 3]   = prog_tab[t];
            exp_addr[t + 3]   = exp_addr[t];
            exp_data[t + 3]   = exp_data[t];
        end
    endtask

    // reset with fresh memories, then check the reset state
    task automatic apply_reset(int t);
        @(posedge clk);
        #2;
        reset_n      = 1'b0;
        random_stall = 1'b0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            imem[i] = (i < prog_len[t]) ? prog_tab[t][i] : 32'h0;
            dmem[i] = 32'hC0DE_0000 ^ (word_t'(i) << 2);
        end
        store_addr_q.delete();
        store_data_q.delete();
        store_strb_q.delete();
        reads_before_store = 0;
        repeat (10) @(posedge clk);
        #1;
        check_value("reset pc", START_ADDRESS, instruction_address_o);
        check_value("reset mem enable", 32'h0, word_t'(mem_operation_enable_o));
        check_value("reset write strobes", 32'h0, word_t'(mem_write_enable_o));
        #1;
        reset_n      = 1'b1;
        random_stall = stall_mode[t];
    endtask

    ////////////////////////////////////////
    // memory models and stall source
    ////////////////////////////////////////
    assign imem_offset = instruction_address_o - START_ADDRESS;

    // answer one cycle after the request
    always @(posedge clk) begin
        instruction_i <= #2 imem[imem_offset[7:2]];
    end

    always @(posedge clk) begin
        mem_data_i <= #2 dmem[mem_address_o[7:2]];
        for (int b = 0; b < 4; b++) begin
            if (mem_write_enable_o[b])
                dmem[mem_address_o[7:2]][b*8 +: 8] = mem_data_o[b*8 +: 8];
        end
    end

    // roughly one stalled cycle in four
    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        stall_i <= #2 random_stall && (lcg_state[17:16] == 2'b11);
    end

    // a held store counts once on its unstalled cycle
    always @(posedge clk) begin
        if (reset_n && !stall_i && mem_operation_enable_o) begin
            if (mem_write_enable_o != 4'b0000) begin
                store_addr_q.push_back(mem_address_o);
                store_data_q.push_back(mem_data_o);
                store_strb_q.push_back(word_t'(mem_write_enable_o));
            end else if (store_addr_q.size() == 0) begin
                reads_before_store++;
            end
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        reset_n = 1'b0;
        errors  = 0;
        passed  = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            int cycles;
            bit timed_out;
            cur_name    = test_name[t];
            test_errors = 0;
            timed_out   = 1'b0;
            apply_reset(t);
            for (int k = 0; k < exp_count[t]; k++) begin
                cycles = 0;
                while (store_addr_q.size() <= k && cycles < STORE_TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (store_addr_q.size() <= k) begin
                    $display("%s: store %0d did not appear within %0d cycles",
                             cur_name, k, STORE_TIMEOUT);
                    test_errors++;
                    timed_out = 1'b1;
                    break;
                end
                check_value($sformatf("store %0d address", k), exp_addr[t][k], store_addr_q[k]);
                check_value($sformatf("store %0d data", k), exp_data[t][k], store_data_q[k]);
                // sw writes every byte lane
                check_value($sformatf("store %0d strobes", k), 32'h0000_000F, store_strb_q[k]);
            end
            // wrong-path or repeated stores would show up here
            if (!timed_out) begin
                repeat (QUIET_CYCLES) @(posedge clk);
                #1;
                check_value("store count", word_t'(exp_count[t]), word_t'(store_addr_q.size()));
                check_value("reads before first store", 32'h0, word_t'(reads_before_store));
            end
            errors += test_errors;
            if (test_errors == 0)
                passed++;
            $display("test %-18s %s", cur_name, (test_errors == 0) ? "ok" : "FAILED");
        end
        $display("%0d of %0d tests ok, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- rs5_lite.f
logic/rs5_isa_pkg.sv
logic/rs5_pipe_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/regbank.sv
logic/execute.sv
logic/retire.sv
logic/rs5_lite.sv
verif/tb_clock_gen.sv
verif/rs5_lite_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rs5_lite testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module rs5_lite_tb \
        -f rs5_lite.f --Mdir obj_dir -o rs5_lite_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/rs5_lite_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
